// File: src.f
core_pkg.sv
isa_pkg.sv
branch_if.sv
fetch_ctrl.sv
reg_file.sv
branch_unit.sv
jump_core.sv
tb_jump_core.sv

// File: tb_jump_core.sv
`timescale 1ns/1ps

module tb_jump_core;
	import core_pkg::*;
	import isa_pkg::*;

	localparam word_t P             = 16'h0040; // Start address under test
	localparam int    FETCH_TIMEOUT = 200;

	logic  clk;
	logic  arst_n;
	logic  imem_req;
	word_t imem_addr;
	logic  imem_ack;
	word_t imem_data;

	word_t       mem [0:65535];
	word_t       trace [$]; // Every fetched address
	word_t       exp_q [$];
	int unsigned lcg_state       = 59908;
	int          value_errors    = 0;
	int          timeout_errors  = 0;
	int          protocol_errors = 0;

	jump_core #(
		.RESET_PC (P)
	) UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.imem_req  (imem_req),
		.imem_addr (imem_addr),
		.imem_ack  (imem_ack),
		.imem_data (imem_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	function automatic word_t enc(opcode_t op, logic [2:0] rx, logic [7:0] low);
		return {op, rx, low};
	endfunction

	function automatic word_t enc_b(int off);
		return {OP_B, 11'(off)};
	endfunction

	// Memory side of the four-phase handshake
	initial begin : responder
		int   delay_left;
		logic req_prev;
		delay_left = -1;
		req_prev   = 1'b0;
		imem_ack   = 1'b0;
		imem_data  = '0;
		forever begin
			@(posedge clk);
			#1;
			if (!arst_n) begin
				imem_ack   = 1'b0;
				delay_left = -1;
			end else begin
				if (imem_req && !req_prev && imem_ack) begin
					$display("Handshake error: req rose at %h while ack was still high", imem_addr);
					protocol_errors++;
				end
				if (imem_ack) begin
					if (!imem_req) begin
						if (delay_left < 0) begin
							delay_left = lcg_next() % 4; // Ack lingers after req drops
						end
						if (delay_left == 0) begin
							imem_ack = 1'b0; // Phase 4
						end
						delay_left--;
					end
				end else if (imem_req) begin
					if (delay_left < 0) begin
						delay_left = lcg_next() % 4;
					end
					if (delay_left == 0) begin
						imem_data = mem[imem_addr];
						imem_ack  = 1'b1;
						trace.push_back(imem_addr);
					end
					delay_left--;
				end
			end
			req_prev = imem_req;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	// Holds the core in reset and refills memory
	task automatic start_program();
		word_t a;
		@(posedge clk);
		#1;
		arst_n = 1'b0;
		for (int i = 0; i < 65536; i++) begin
			a      = word_t'(i);
			mem[i] = {5'b00001, a[10:0] ^ {6'b0, a[15:11]}}; // Non-control filler
		end
		trace.delete();
		exp_q.delete();
	endtask

	task automatic run_program(input string name);
		int cycles;
		cycles = 0;
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;
		while (trace.size() < exp_q.size() && cycles < FETCH_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (trace.size() < exp_q.size()) begin
			$display("%s: fetch %0d did not happen within %0d cycles", name, trace.size(),
				FETCH_TIMEOUT);
			timeout_errors++;
		end
		for (int i = 0; i < exp_q.size() && i < trace.size(); i++) begin
			check_value($sformatf("%s fetch %0d", name, i), exp_q[i], trace[i]);
		end
	endtask

	task automatic sequential_fetch();
		start_program();
		exp_q = '{P, P + 16'd1, P + 16'd2, P + 16'd3, P + 16'd4, P + 16'd5};
		run_program("seq_fetch");
	endtask

	task automatic branch_uncond();
		start_program();
		mem[P]          = enc_b(256);
		mem[P + 16'd256] = enc_b(-200);
		exp_q = '{P, P + 16'd256, P + 16'd256 - 16'd200, P + 16'd57};
		run_program("branch_b");
	endtask

	task automatic branch_reg_zero();
		start_program();
		mem[P]          = enc(OP_LI, 3'd1, 8'h00);
		mem[P + 16'd1]  = enc(OP_BEQZ, 3'd1, 8'(4));   // Taken
		mem[P + 16'd5]  = enc(OP_BNEZ, 3'd1, 8'(3));   // Falls through
		mem[P + 16'd6]  = enc(OP_LI, 3'd2, 8'h7f);
		mem[P + 16'd7]  = enc(OP_BNEZ, 3'd2, 8'(10));
		mem[P + 16'd17] = enc(OP_BEQZ, 3'd2, 8'(-8));
		mem[P + 16'd18] = enc(OP_BNEZ, 3'd2, 8'(-16));
		exp_q = '{P, P + 16'd1, P + 16'd1 + 16'd4, P + 16'd6, P + 16'd7,
			P + 16'd7 + 16'd10, P + 16'd18, P + 16'd18 - 16'd16};
		run_program("beqz_bnez");
	endtask

	task automatic branch_t_flag();
		start_program();
		mem[P]          = enc(OP_LI, 3'd3, 8'h05);
		mem[P + 16'd1]  = enc(OP_CMPI, 3'd3, 8'h05);   // T becomes 0
		mem[P + 16'd2]  = enc(OP_TGRP, TFUNC_BTEQZ, 8'(6));
		mem[P + 16'd8]  = enc(OP_TGRP, TFUNC_BTNEZ, 8'(4));
		mem[P + 16'd9]  = enc(OP_CMPI, 3'd3, 8'hff);   // 0xffff vs 5, T becomes 1
		mem[P + 16'd10] = enc(OP_TGRP, TFUNC_BTEQZ, 8'(2));
		mem[P + 16'd11] = enc(OP_TGRP, TFUNC_BTNEZ, 8'(-9));
		exp_q = '{P, P + 16'd1, P + 16'd2, P + 16'd2 + 16'd6, P + 16'd9, P + 16'd10,
			P + 16'd11, P + 16'd11 - 16'd9, P + 16'd3};
		run_program("cmpi_bt");
	endtask

	task automatic jump_reg();
		start_program();
		mem[P]         = enc(OP_LI, 3'd4, 8'ha0);
		mem[P + 16'd1] = enc(OP_JGRP, 3'd4, JFUNC_JR);
		exp_q = '{P, P + 16'd1, 16'h00a0, 16'h00a1};
		run_program("jr");
	endtask

	task automatic call_return();
		start_program();
		mem[P]         = enc(OP_LI, 3'd5, 8'h90);
		mem[P + 16'd1] = enc(OP_JGRP, 3'd5, JFUNC_JALR);
		mem[16'h0090]  = enc(OP_JGRP, 3'd0, JFUNC_JRRA); // Back to JALR plus one
		exp_q = '{P, P + 16'd1, 16'h0090, P + 16'd2, P + 16'd3};
		run_program("jalr_jrra");
	endtask

	initial begin
		arst_n = 1'b0;
		sequential_fetch();
		branch_uncond();
		branch_reg_zero();
		branch_t_flag();
		jump_reg();
		call_return();
		$display("Errors: %0d value, %0d timeout, %0d handshake", value_errors,
			timeout_errors, protocol_errors);
		if (value_errors + timeout_errors + protocol_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: jump_core.sv
`timescale 1ns/1ps

module jump_core #(
	parameter core_pkg::word_t RESET_PC = 16'h0000
) (
	input  logic            clk,
	input  logic            arst_n,
	output logic            imem_req,
	output core_pkg::word_t imem_addr,
	input  logic            imem_ack,
	input  core_pkg::word_t imem_data
);
	import core_pkg::*;

	word_t pc;
	word_t instr;
	logic  exec; // Write strobe from fetch

	branch_if br_bus ();

	fetch_ctrl #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk       (clk),
		.arst_n    (arst_n),
		.set_pc    (br_bus.set_pc),
		.target    (br_bus.target),
		.imem_ack  (imem_ack),
		.imem_data (imem_data),
		.imem_req  (imem_req),
		.imem_addr (imem_addr),
		.pc        (pc),
		.instr     (instr),
		.exec      (exec)
	);

	reg_file u_regs (
		.clk    (clk),
		.arst_n (arst_n),
		.exec   (exec),
		.pc     (pc),
		.instr  (instr),
		.bus    (br_bus)
	);

	branch_unit u_branch (
		.bus (br_bus)
	);

endmodule

// File: branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
	branch_if.branch bus
);
	import core_pkg::*;
	import isa_pkg::*;

	opcode_t opc;
	tfunc_t  tfunc;
	jfunc_t  jfunc;
	logic    op1_zero;
	word_t   pc_next;
	word_t   short_target; // 8-bit offset form
	word_t   long_target;  // B only

	assign opc          = opcode_of(bus.instr);
	assign tfunc        = tfunc_of(bus.instr);
	assign jfunc        = jfunc_of(bus.instr);
	assign op1_zero     = (bus.op1 == '0);
	assign pc_next      = bus.pc + 1'b1;
	assign short_target = bus.pc + imm8_sext(bus.instr);
	assign long_target  = bus.pc + imm11_sext(bus.instr);

	assign bus.ra_value = pc_next;

	always_comb begin
		bus.set_pc   = 1'b0;
		bus.target   = '0;
		bus.write_ra = 1'b0;
		case (opc)
			OP_B: begin
				bus.set_pc = 1'b1;
				bus.target = long_target;
			end
			OP_BEQZ: begin
				if (op1_zero) begin
					bus.set_pc = 1'b1;
					bus.target = short_target;
				end
			end
			OP_BNEZ: begin
				if (!op1_zero) begin
					bus.set_pc = 1'b1;
					bus.target = short_target;
				end
			end
			OP_TGRP: begin
				case (tfunc)
					TFUNC_BTEQZ: begin
						if (op1_zero) begin
							bus.set_pc = 1'b1;
							bus.target = short_target;
						end
					end
					TFUNC_BTNEZ: begin
						if (!op1_zero) begin
							bus.set_pc = 1'b1;
							bus.target = short_target;
						end
					end
					default: begin
					end
				endcase
			end
			OP_JGRP: begin
				if (jfunc == JFUNC_JR || jfunc == JFUNC_JALR || is_jrra(bus.instr)) begin
					bus.set_pc = 1'b1;
					bus.target = bus.op1; // Register indirect
				end
				if (jfunc == JFUNC_JALR) begin
					bus.write_ra = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            exec,
	input  core_pkg::word_t pc,
	input  core_pkg::word_t instr,
	branch_if.regs          bus
);
	import core_pkg::*;
	import isa_pkg::*;

	word_t    gpr [NUM_GPR];
	word_t    t_reg;
	word_t    ra_reg;
	reg_idx_t rx;
	opcode_t  opc;
	logic     cmp_eq;

	assign rx     = rx_of(instr);
	assign opc    = opcode_of(instr);
	assign cmp_eq = (gpr[rx] == imm8_sext(instr)); // CMPI compare

	assign bus.pc    = pc;
	assign bus.instr = instr;

	always_comb begin
		if (opc == OP_TGRP) begin
			bus.op1 = t_reg; // BTEQZ and BTNEZ test T
		end else if (is_jrra(instr)) begin
			bus.op1 = ra_reg;
		end else begin
			bus.op1 = gpr[rx];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_GPR; i++) begin
				gpr[i] <= '0;
			end
			t_reg  <= '0;
			ra_reg <= '0;
		end else if (exec) begin
			case (opc)
				OP_LI: begin
					gpr[rx] <= imm8_zext(instr);
				end
				OP_CMPI: begin
					t_reg <= cmp_eq ? word_t'(0) : word_t'(1); // Zero on match
				end
				default: begin
				end
			endcase
			if (bus.write_ra) begin
				ra_reg <= bus.ra_value;
			end
		end
	end

endmodule

// File: fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl #(
	parameter core_pkg::word_t RESET_PC = 16'h0000
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            set_pc,
	input  core_pkg::word_t target,
	input  logic            imem_ack,
	input  core_pkg::word_t imem_data,
	output logic            imem_req,
	output core_pkg::word_t imem_addr,
	output core_pkg::word_t pc,
	output core_pkg::word_t instr,
	output logic            exec
);
	import core_pkg::*;

	fetch_state_t state;
	word_t        pc_q;
	word_t        ir_q;
	logic         req_q;
	logic         fetch_done;

	assign fetch_done = (state == F_REQ) && req_q && imem_ack; // Data valid on this edge

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= F_REQ;
			req_q <= 1'b0;
			pc_q  <= RESET_PC;
		end else begin
			case (state)
				F_REQ: begin
					if (fetch_done) begin
						req_q <= 1'b0; // Phase 3 drops req
						state <= F_RELEASE;
					end else begin
						req_q <= 1'b1;
					end
				end
				F_RELEASE: begin
					if (!imem_ack) begin
						state <= F_EXEC;
					end
				end
				F_EXEC: begin
					if (set_pc) begin
						pc_q <= target;
					end else begin
						pc_q <= pc_q + 1'b1;
					end
					req_q <= 1'b1; // Ack already low here
					state <= F_REQ;
				end
				default: begin
					req_q <= 1'b0;
					state <= F_REQ;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_done) begin
			ir_q <= imem_data;
		end
	end

	assign imem_req  = req_q;
	assign imem_addr = pc_q; // Stable while req is high
	assign pc        = pc_q;
	assign instr     = ir_q;
	assign exec      = (state == F_EXEC);

endmodule

// File: branch_if.sv
`timescale 1ns/1ps

interface branch_if;
	import core_pkg::*;

	word_t op1;      // Selected operand
	word_t pc;       // Address of current instruction
	word_t instr;
	logic  set_pc;   // Redirect request
	word_t target;
	logic  write_ra;
	word_t ra_value; // Link address for JALR

	modport regs (
		output op1,
		output pc,
		output instr,
		input  write_ra,
		input  ra_value
	);

	modport branch (
		input  op1,
		input  pc,
		input  instr,
		output set_pc,
		output target,
		output write_ra,
		output ra_value
	);

endinterface

// File: isa_pkg.sv
package isa_pkg;

	localparam int OPC_HI   = 15;
	localparam int OPC_LO   = 11;
	localparam int RX_HI    = 10;
	localparam int RX_LO    = 8;
	localparam int IMM8_HI  = 7;
	localparam int IMM11_HI = 10;
	localparam int INSTR_W  = 16;

	typedef enum logic [4:0] {
		OP_B    = 5'b00010,
		OP_BEQZ = 5'b00100,
		OP_BNEZ = 5'b00101,
		OP_TGRP = 5'b01100,
		OP_LI   = 5'b01101,
		OP_CMPI = 5'b01110,
		OP_JGRP = 5'b11101
	} opcode_t;

	typedef logic [RX_HI-RX_LO:0] tfunc_t;
	typedef logic [IMM8_HI:0]     jfunc_t;

	localparam tfunc_t TFUNC_BTEQZ = 3'b000;
	localparam tfunc_t TFUNC_BTNEZ = 3'b001;

	localparam jfunc_t JFUNC_JR   = 8'b00000000;
	localparam jfunc_t JFUNC_JALR = 8'b11000000;
	localparam jfunc_t JFUNC_JRRA = 8'b00100000;

	function automatic opcode_t opcode_of(logic [INSTR_W-1:0] ir);
		return opcode_t'(ir[OPC_HI:OPC_LO]);
	endfunction

	function automatic logic [RX_HI-RX_LO:0] rx_of(logic [INSTR_W-1:0] ir);
		return ir[RX_HI:RX_LO];
	endfunction

	function automatic tfunc_t tfunc_of(logic [INSTR_W-1:0] ir);
		return ir[RX_HI:RX_LO];
	endfunction

	function automatic jfunc_t jfunc_of(logic [INSTR_W-1:0] ir);
		return ir[IMM8_HI:0];
	endfunction

	function automatic logic [INSTR_W-1:0] imm8_zext(logic [INSTR_W-1:0] ir);
		return {{(INSTR_W-1-IMM8_HI){1'b0}}, ir[IMM8_HI:0]};
	endfunction

	function automatic logic [INSTR_W-1:0] imm8_sext(logic [INSTR_W-1:0] ir);
		return {{(INSTR_W-1-IMM8_HI){ir[IMM8_HI]}}, ir[IMM8_HI:0]};
	endfunction

	function automatic logic [INSTR_W-1:0] imm11_sext(logic [INSTR_W-1:0] ir);
		return {{(INSTR_W-1-IMM11_HI){ir[IMM11_HI]}}, ir[IMM11_HI:0]};
	endfunction

	// JRRA needs a zero rx field as well
	function automatic logic is_jrra(logic [INSTR_W-1:0] ir);
		return (opcode_of(ir) == OP_JGRP) && (tfunc_of(ir) == '0)
			&& (jfunc_of(ir) == JFUNC_JRRA);
	endfunction

endpackage

// File: core_pkg.sv
package core_pkg;

	localparam int WORD_W  = 16;
	localparam int NUM_GPR = 8;

	typedef logic [WORD_W-1:0]          word_t;
	typedef logic [$clog2(NUM_GPR)-1:0] reg_idx_t;

	typedef enum logic [1:0] {
		F_REQ,     // Request held until ack
		F_RELEASE, // Wait for ack to drop
		F_EXEC     // Single execute cycle
	} fetch_state_t;

endpackage
